// ==== rtl/ifs_pkg.sv ====
// Shared types, opcodes and constants of the fetch stage, imported by every RTL file and the testbench
package ifs_pkg;

  //////////////////////////////
  // Privilege and fetch words
  //////////////////////////////

  // Only user and machine mode exist in this core
  typedef enum logic [1:0] {
    PRIV_LVL_U = 2'b00,
    PRIV_LVL_M = 2'b11
  } privlvl_t;

  // The two halves of a fetched word, upper half first as in memory bit order
  typedef struct packed {
    logic [15:0] hi;
    logic [15:0] lo;
  } halfword_pair_t;

  // A fetched word is read whole as an instruction or split into halfwords by the aligner
  typedef union packed {
    logic [31:0]    instr;
    halfword_pair_t half;
  } fetch_word_u;

  //////////////////////////////
  // Bus and control
  //////////////////////////////

  typedef struct packed {
    logic        req;
    logic [31:0] addr;
  } obi_req_t;

  typedef struct packed {
    logic        gnt;
    logic        rvalid;
    logic [31:0] rdata;
  } obi_resp_t;

  // Command from the controller, branch_addr and priv_lvl only matter with kill_if
  typedef struct packed {
    logic        halt_if;
    logic        kill_if;
    logic [31:0] branch_addr;
    privlvl_t    priv_lvl;
  } ctrl_fsm_t;

  // IF/ID pipeline register, 70 bits
  typedef struct packed {
    logic        instr_valid;
    logic [31:0] instr;
    logic [31:0] pc;
    privlvl_t    priv_lvl;
    logic        compressed;
    logic        illegal_c_insn;
    logic        dummy;
  } if_id_pipe_t;

  // Major opcodes produced by the compressed expansion
  localparam logic [6:0] OPCODE_OP    = 7'h33;
  localparam logic [6:0] OPCODE_OPIMM = 7'h13;
  localparam logic [6:0] OPCODE_LOAD  = 7'h03;
  localparam logic [6:0] OPCODE_STORE = 7'h23;
  localparam logic [6:0] OPCODE_JAL   = 7'h6f;

  // ADD x0,x0,x0 has no architectural effect, so it serves as the dummy
  localparam logic [31:0] DUMMY_INSTR = {7'b0, 5'd0, 5'd0, 3'b000, 5'd0, OPCODE_OP};

  // Defaults for the top-level parameters
  localparam logic [31:0] BOOT_ADDR_DEFAULT = 32'h0000_0080;
  localparam logic [15:0] LFSR_SEED_DEFAULT = 16'hace1;

endpackage

// ==== rtl/ifs_prefetch_buffer.sv ====
// Word prefetcher for the fetch stage; issues bus requests and hands buffered words to the aligner
`timescale 1ns/1ps

module ifs_prefetch_buffer #(
  parameter logic [31:0] BOOT_ADDR = ifs_pkg::BOOT_ADDR_DEFAULT
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 kill_i,
  input  logic [31:0]          branch_addr_i,
  output ifs_pkg::obi_req_t    obi_req_o,
  input  ifs_pkg::obi_resp_t   obi_resp_i,
  output ifs_pkg::fetch_word_u word_o,
  output logic [31:0]          word_addr_o,
  output logic                 word_valid_o,
  input  logic                 pop_i
);
  import ifs_pkg::*;

  localparam logic [31:0] BOOT_WORD = {BOOT_ADDR[31:2], 2'b00};

  logic [31:0] branch_word;
  logic [31:0] base_addr;
  logic [31:0] fetch_addr_q;
  logic [31:0] fetch_addr_n;
  logic        req_q;
  logic        req_n;
  logic [31:0] req_addr_q;
  logic [31:0] req_addr_n;
  logic [31:0] head_addr_q;
  logic [1:0]  out_q;
  logic [1:0]  out_n;
  logic [1:0]  disc_q;
  logic [1:0]  disc_n;
  logic [1:0]  cnt_q;
  logic [1:0]  cnt_n;
  logic        rd_ptr_q;
  logic        wr_ptr_q;
  logic        granted;
  logic        hold_req;
  logic        drop_resp;
  logic        push;
  logic        do_pop;
  logic        can_issue;
  fetch_word_u fifo_q [2];

  assign branch_word = {branch_addr_i[31:2], 2'b00};
  assign granted     = req_q & obi_resp_i.gnt;
  // A request without grant must keep req and addr as they are
  assign hold_req    = req_q & ~obi_resp_i.gnt;
  // Responses to requests issued before a kill are counted away here
  assign drop_resp   = (disc_q != 2'd0);
  assign push        = obi_resp_i.rvalid & ~drop_resp & ~kill_i;
  assign do_pop      = pop_i & (cnt_q != 2'd0) & ~kill_i;

  assign out_n     = out_q + {1'b0, granted} - {1'b0, obi_resp_i.rvalid};
  assign cnt_n     = kill_i ? 2'd0 : cnt_q + {1'b0, push} - {1'b0, do_pop};
  assign base_addr = kill_i ? branch_word : fetch_addr_q;
  // Buffered words plus requests in flight never exceed two
  assign can_issue = ({1'b0, cnt_n} + {1'b0, out_n}) < 3'd2;

  always_comb begin
    disc_n = disc_q;
    if (kill_i) begin
      // Everything in flight is stale, including a request still waiting for its grant
      disc_n = out_n + {1'b0, hold_req};
    end else if (obi_resp_i.rvalid && drop_resp) begin
      disc_n = disc_q - 2'd1;
    end
  end

  always_comb begin
    req_n        = req_q;
    req_addr_n   = req_addr_q;
    fetch_addr_n = base_addr;
    if (!hold_req) begin
      req_n = can_issue;
      if (can_issue) begin
        req_addr_n   = base_addr;
        fetch_addr_n = base_addr + 32'd4;
      end
    end
  end

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      req_q        <= 1'b0;
      req_addr_q   <= BOOT_WORD;
      fetch_addr_q <= BOOT_WORD;
      head_addr_q  <= BOOT_WORD;
      out_q        <= 2'd0;
      disc_q       <= 2'd0;
      cnt_q        <= 2'd0;
      rd_ptr_q     <= 1'b0;
      wr_ptr_q     <= 1'b0;
    end else begin
      req_q        <= req_n;
      req_addr_q   <= req_addr_n;
      fetch_addr_q <= fetch_addr_n;
      out_q        <= out_n;
      disc_q       <= disc_n;
      cnt_q        <= cnt_n;
      if (kill_i) begin
        rd_ptr_q    <= 1'b0;
        wr_ptr_q    <= 1'b0;
        head_addr_q <= branch_word;
      end else begin
        if (push) begin
          wr_ptr_q <= ~wr_ptr_q;
        end
        if (do_pop) begin
          rd_ptr_q    <= ~rd_ptr_q;
          head_addr_q <= head_addr_q + 32'd4;
        end
      end
    end
  end

  // Word storage
  always_ff @(posedge clk) begin
    if (push) begin
      fifo_q[wr_ptr_q].instr <= obi_resp_i.rdata;
    end
  end

  assign obi_req_o.req  = req_q;
  assign obi_req_o.addr = req_addr_q;
  assign word_o         = fifo_q[rd_ptr_q];
  assign word_addr_o    = head_addr_q;
  assign word_valid_o   = (cnt_q != 2'd0);

endmodule

// ==== rtl/ifs_aligner.sv ====
// Instruction aligner; cuts buffered words into 16 and 32-bit instructions at halfword addresses
`timescale 1ns/1ps

module ifs_aligner (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 kill_i,
  input  logic                 start_half_i,
  input  ifs_pkg::fetch_word_u word_i,
  input  logic [31:0]          word_addr_i,
  input  logic                 word_valid_i,
  output logic                 pop_o,
  output logic [31:0]          instr_o,
  output logic                 compressed_o,
  output logic [31:0]          pc_o,
  output logic                 valid_o,
  input  logic                 ready_i
);

  // Set when the next instruction starts in the upper half of the head word
  logic        half_q;
  // Set when residue_q holds the low half of a 32-bit instruction that crosses a word
  logic        res_valid_q;
  logic [15:0] residue_q;
  logic        lo_is_c;
  logic        hi_is_c;
  logic        issue;
  logic        spill;

  assign lo_is_c = (word_i.half.lo[1:0] != 2'b11);
  assign hi_is_c = (word_i.half.hi[1:0] != 2'b11);
  assign issue   = valid_o & ready_i;

  // Upper half starts a 32-bit instruction, so park it and wait for the next word
  assign spill = half_q & ~res_valid_q & ~hi_is_c & word_valid_i & ~kill_i;

  always_comb begin
    instr_o      = word_i.instr;
    compressed_o = 1'b0;
    pc_o         = word_addr_i;
    valid_o      = word_valid_i;
    if (res_valid_q) begin
      // Head word is the one after the parked half
      instr_o = {word_i.half.lo, residue_q};
      pc_o    = word_addr_i - 32'd2;
    end else if (!half_q) begin
      compressed_o = lo_is_c;
    end else begin
      instr_o      = {16'h0000, word_i.half.hi};
      compressed_o = hi_is_c;
      pc_o         = word_addr_i + 32'd2;
      valid_o      = word_valid_i & hi_is_c;
    end
  end

  // The head word is used up by a full aligned word, an upper compressed half or a spill
  assign pop_o = spill | (issue & ~res_valid_q & (half_q | ~lo_is_c));

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      half_q      <= 1'b0;
      res_valid_q <= 1'b0;
    end else if (kill_i) begin
      half_q      <= start_half_i;
      res_valid_q <= 1'b0;
    end else if (spill) begin
      half_q      <= 1'b0;
      res_valid_q <= 1'b1;
    end else if (issue) begin
      if (res_valid_q) begin
        // Low half of the head word went with the residue
        res_valid_q <= 1'b0;
        half_q      <= 1'b1;
      end else if (!half_q) begin
        half_q <= lo_is_c;
      end else begin
        half_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (spill) begin
      residue_q <= word_i.half.hi;
    end
  end

endmodule

// ==== rtl/ifs_compressed_decoder.sv ====
// Combinational RVC expander for the supported subset, flags all other compressed encodings
`timescale 1ns/1ps

module ifs_compressed_decoder (
  input  logic [31:0] instr_i,
  input  logic        compressed_i,
  output logic [31:0] instr_o,
  output logic        illegal_c_insn_o
);
  import ifs_pkg::*;

  logic [15:0] c;
  logic [4:0]  c_rd;
  logic [4:0]  c_rs2;
  // Three-bit register fields address x8 to x15
  logic [4:0]  c_rdp;
  logic [4:0]  c_rs1p;
  logic [11:0] c_imm;

  assign c      = instr_i[15:0];
  assign c_rd   = c[11:7];
  assign c_rs2  = c[6:2];
  assign c_rdp  = {2'b01, c[4:2]};
  assign c_rs1p = {2'b01, c[9:7]};
  // Six-bit signed immediate of C.ADDI and C.LI
  assign c_imm  = {{7{c[12]}}, c[6:2]};

  always_comb begin
    instr_o          = instr_i;
    illegal_c_insn_o = 1'b0;
    if (compressed_i) begin
      // Unsupported or reserved encodings fall through unexpanded
      illegal_c_insn_o = 1'b1;
      case (c[1:0])
        2'b00: begin
          case (c[15:13])
            3'b010: begin
              // C.LW becomes lw rd', uimm(rs1')
              instr_o = {5'b00000, c[5], c[12:10], c[6], 2'b00, c_rs1p, 3'b010,
                         c_rdp, OPCODE_LOAD};
              illegal_c_insn_o = 1'b0;
            end
            3'b110: begin
              // C.SW becomes sw rs2', uimm(rs1')
              instr_o = {5'b00000, c[5], c[12], c_rdp, c_rs1p, 3'b010,
                         c[11:10], c[6], 2'b00, OPCODE_STORE};
              illegal_c_insn_o = 1'b0;
            end
            default: ;
          endcase
        end
        2'b01: begin
          case (c[15:13])
            3'b000: begin
              // C.ADDI becomes addi rd, rd, imm
              instr_o          = {c_imm, c_rd, 3'b000, c_rd, OPCODE_OPIMM};
              illegal_c_insn_o = 1'b0;
            end
            3'b010: begin
              // C.LI becomes addi rd, x0, imm
              instr_o          = {c_imm, 5'd0, 3'b000, c_rd, OPCODE_OPIMM};
              illegal_c_insn_o = 1'b0;
            end
            3'b101: begin
              // C.J becomes jal x0 with the scrambled offset put back in JAL order
              instr_o = {c[12], c[8], c[10:9], c[6], c[7], c[2], c[11], c[5:3],
                         c[12], {8{c[12]}}, 5'd0, OPCODE_JAL};
              illegal_c_insn_o = 1'b0;
            end
            default: ;
          endcase
        end
        2'b10: begin
          // C.MV and C.ADD share funct3 100, rs2 of zero would mean C.JR or C.JALR
          if (c[15:13] == 3'b100 && c_rs2 != 5'd0) begin
            if (c[12]) begin
              instr_o = {7'b0, c_rs2, c_rd, 3'b000, c_rd, OPCODE_OP};
            end else begin
              instr_o = {7'b0, c_rs2, 5'd0, 3'b000, c_rd, OPCODE_OP};
            end
            illegal_c_insn_o = 1'b0;
          end
        end
        default: ;
      endcase
    end
  end

endmodule

// ==== rtl/ifs_dummy_inserter.sv ====
// LFSR-driven decision of when a dummy instruction takes the next issue slot of the fetch stage
`timescale 1ns/1ps

module ifs_dummy_inserter #(
  parameter logic [15:0] LFSR_SEED = ifs_pkg::LFSR_SEED_DEFAULT
) (
  input  logic clk,
  input  logic rst_n,
  input  logic dummy_en_i,
  input  logic issue_i,
  output logic dummy_insert_o
);

  // The seed has to be nonzero or the LFSR never leaves zero
  logic [15:0] lfsr_q;
  logic        feedback;
  // Set for the slot that follows an issued dummy
  logic        last_dummy_q;

  // Taps for x^16 + x^14 + x^13 + x^11 + 1, a maximal length sequence
  assign feedback = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];

  // Roughly one slot in eight, and never two in a row
  assign dummy_insert_o = dummy_en_i & (lfsr_q[2:0] == 3'b000) & ~last_dummy_q;

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      lfsr_q       <= LFSR_SEED;
      last_dummy_q <= 1'b0;
    end else if (issue_i) begin
      // Only a used slot moves the sequence on, so a stalled decision stays stable
      lfsr_q       <= {lfsr_q[14:0], feedback};
      last_dummy_q <= dummy_insert_o;
    end
  end

endmodule

// ==== rtl/ifs_if_stage.sv ====
// Top of the instruction-fetch stage; connects prefetch, aligner, decoder and dummy logic to IF/ID
`timescale 1ns/1ps

module ifs_if_stage #(
  parameter logic [31:0] BOOT_ADDR = ifs_pkg::BOOT_ADDR_DEFAULT,
  parameter logic [15:0] LFSR_SEED = ifs_pkg::LFSR_SEED_DEFAULT
) (
  input  logic                 clk,
  input  logic                 rst_n,
  output ifs_pkg::obi_req_t    obi_req_o,
  input  ifs_pkg::obi_resp_t   obi_resp_i,
  input  ifs_pkg::ctrl_fsm_t   ctrl_fsm_i,
  input  logic                 dummy_en_i,
  output ifs_pkg::if_id_pipe_t if_id_pipe_o,
  output logic                 if_valid_o,
  input  logic                 id_ready_i
);
  import ifs_pkg::*;

  fetch_word_u pf_word;
  logic [31:0] pf_word_addr;
  logic        pf_valid;
  logic        pf_pop;
  logic [31:0] al_instr;
  logic [31:0] al_pc;
  logic        al_compressed;
  logic        aligned_valid;
  logic [31:0] dec_instr;
  logic        illegal_c_insn;
  logic        dummy_insert;
  logic        if_ready;
  logic        issue_ready;
  logic        issue;
  privlvl_t    priv_q;
  if_id_pipe_t pipe_q;

  //////////////////////////////
  // Fetch datapath
  //////////////////////////////

  ifs_prefetch_buffer #(
    .BOOT_ADDR (BOOT_ADDR)
  ) prefetch_buffer_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .kill_i        (ctrl_fsm_i.kill_if),
    .branch_addr_i (ctrl_fsm_i.branch_addr),
    .obi_req_o     (obi_req_o),
    .obi_resp_i    (obi_resp_i),
    .word_o        (pf_word),
    .word_addr_o   (pf_word_addr),
    .word_valid_o  (pf_valid),
    .pop_i         (pf_pop)
  );

  // Bit 1 of the target picks the half where the aligner resumes
  ifs_aligner aligner_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .kill_i       (ctrl_fsm_i.kill_if),
    .start_half_i (ctrl_fsm_i.branch_addr[1]),
    .word_i       (pf_word),
    .word_addr_i  (pf_word_addr),
    .word_valid_i (pf_valid),
    .pop_o        (pf_pop),
    .instr_o      (al_instr),
    .compressed_o (al_compressed),
    .pc_o         (al_pc),
    .valid_o      (aligned_valid),
    .ready_i      (issue_ready)
  );

  ifs_compressed_decoder compressed_decoder_i (
    .instr_i          (al_instr),
    .compressed_i     (al_compressed),
    .instr_o          (dec_instr),
    .illegal_c_insn_o (illegal_c_insn)
  );

  ifs_dummy_inserter #(
    .LFSR_SEED (LFSR_SEED)
  ) dummy_inserter_i (
    .clk            (clk),
    .rst_n          (rst_n),
    .dummy_en_i     (dummy_en_i),
    .issue_i        (issue),
    .dummy_insert_o (dummy_insert)
  );

  //////////////////////////////
  // Issue control
  //////////////////////////////

  // The pipe takes a new entry when it is empty or decode drains it this cycle
  assign if_ready    = ~ctrl_fsm_i.halt_if & ~ctrl_fsm_i.kill_if &
                       (~pipe_q.instr_valid | id_ready_i);
  // A dummy uses the slot but leaves the aligned instruction where it is
  assign issue_ready = if_ready & ~dummy_insert;
  assign issue       = if_ready & aligned_valid;

  // Privilege of everything fetched after a kill
  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      priv_q <= PRIV_LVL_M;
    end else if (ctrl_fsm_i.kill_if) begin
      priv_q <= ctrl_fsm_i.priv_lvl;
    end
  end

  // IF/ID register
  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      pipe_q          <= '0;
      pipe_q.priv_lvl <= PRIV_LVL_M;
    end else if (ctrl_fsm_i.kill_if) begin
      pipe_q.instr_valid <= 1'b0;
    end else if (if_ready) begin
      pipe_q.instr_valid <= aligned_valid;
      if (aligned_valid) begin
        pipe_q.instr          <= dummy_insert ? DUMMY_INSTR : dec_instr;
        // A dummy reports the pc of the instruction it precedes
        pipe_q.pc             <= al_pc;
        pipe_q.priv_lvl       <= priv_q;
        pipe_q.compressed     <= al_compressed & ~dummy_insert;
        pipe_q.illegal_c_insn <= illegal_c_insn & ~dummy_insert;
        pipe_q.dummy          <= dummy_insert;
      end
    end
  end

  assign if_id_pipe_o = pipe_q;
  // Halt and kill hide the held entry from decode in the same cycle
  assign if_valid_o   = pipe_q.instr_valid & ~ctrl_fsm_i.halt_if & ~ctrl_fsm_i.kill_if;

endmodule

// ==== sim/ifs_if_stage_chk.sv ====
// Concurrent checks on the ports of the fetch stage, bound to every ifs_if_stage by the testbench
`timescale 1ns/1ps

module ifs_if_stage_chk (
  input logic                 clk,
  input logic                 rst_n,
  input ifs_pkg::obi_req_t    obi_req_o,
  input ifs_pkg::obi_resp_t   obi_resp_i,
  input ifs_pkg::ctrl_fsm_t   ctrl_fsm_i,
  input logic                 dummy_en_i,
  input ifs_pkg::if_id_pipe_t if_id_pipe_o,
  input logic                 if_valid_o,
  input logic                 id_ready_i
);
  import ifs_pkg::*;

  // Number of failed assertions so far, the testbench watches it
  int unsigned fail_count = 0;

  // Set while a request from last cycle is still waiting for its grant
  logic        req_open_q;
  // Set from a kill until the first new request after it
  logic        kill_pend_q;
  logic [31:0] kill_word_q;
  // Last accepted entry since the latest kill was a dummy
  logic        acc_dummy_q;
  logic        new_req;
  logic        halt_only;
  logic        load;
  logic        accept;

  assign new_req   = obi_req_o.req & ~req_open_q;
  assign halt_only = ctrl_fsm_i.halt_if & ~ctrl_fsm_i.kill_if;
  // The IF/ID register takes a new entry when it is empty or drained
  assign load      = ~ctrl_fsm_i.halt_if & ~ctrl_fsm_i.kill_if &
                     (~if_id_pipe_o.instr_valid | id_ready_i);
  assign accept    = if_valid_o & id_ready_i;

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      req_open_q  <= 1'b0;
      kill_pend_q <= 1'b0;
      kill_word_q <= '0;
      acc_dummy_q <= 1'b0;
    end else begin
      req_open_q <= obi_req_o.req & ~obi_resp_i.gnt;
      if (ctrl_fsm_i.kill_if) begin
        kill_pend_q <= 1'b1;
        kill_word_q <= {ctrl_fsm_i.branch_addr[31:2], 2'b00};
        acc_dummy_q <= 1'b0;
      end else begin
        if (new_req) begin
          kill_pend_q <= 1'b0;
        end
        if (accept) begin
          acc_dummy_q <= if_id_pipe_o.dummy;
        end
      end
    end
  end

  //////////////////////////////
  // Bus side
  //////////////////////////////

  assert property (@(posedge clk) disable iff (!rst_n)
    obi_req_o.req |-> obi_req_o.addr[1:0] == 2'b00)
    else begin
      fail_count++;
      $error("bus address is not word aligned");
    end

  // A waiting request keeps req and addr until the grant
  assert property (@(posedge clk) disable iff (!rst_n)
    obi_req_o.req && !obi_resp_i.gnt |=> obi_req_o.req && $stable(obi_req_o.addr))
    else begin
      fail_count++;
      $error("request changed before its grant");
    end

  assert property (@(posedge clk) disable iff (!rst_n)
    kill_pend_q && new_req |-> obi_req_o.addr == kill_word_q)
    else begin
      fail_count++;
      $error("first request after a kill is not the word of the branch target");
    end

  //////////////////////////////
  // ID side
  //////////////////////////////

  assert property (@(posedge clk) disable iff (!rst_n)
    ctrl_fsm_i.halt_if || ctrl_fsm_i.kill_if |-> !if_valid_o)
    else begin
      fail_count++;
      $error("if_valid_o high during halt or kill");
    end

  assert property (@(posedge clk) disable iff (!rst_n)
    halt_only |=> $stable(if_id_pipe_o))
    else begin
      fail_count++;
      $error("IF/ID register changed during halt");
    end

  // Back-pressure holds the entry, only halt or kill may hide it
  assert property (@(posedge clk) disable iff (!rst_n)
    if_valid_o && !id_ready_i |=> $stable(if_id_pipe_o) &&
      (if_valid_o || ctrl_fsm_i.halt_if || ctrl_fsm_i.kill_if))
    else begin
      fail_count++;
      $error("IF/ID register or if_valid_o moved under back-pressure");
    end

  assert property (@(posedge clk) disable iff (!rst_n)
    if_valid_o && if_id_pipe_o.dummy |-> if_id_pipe_o.instr == DUMMY_INSTR)
    else begin
      fail_count++;
      $error("dummy entry does not carry the dummy encoding");
    end

  assert property (@(posedge clk) disable iff (!rst_n)
    accept && if_id_pipe_o.dummy |-> !acc_dummy_q)
    else begin
      fail_count++;
      $error("two dummies accepted back to back");
    end

  assert property (@(posedge clk) disable iff (!rst_n)
    load && !dummy_en_i |=> !(if_id_pipe_o.instr_valid && if_id_pipe_o.dummy))
    else begin
      fail_count++;
      $error("dummy loaded while dummy_en_i was low");
    end

endmodule

// ==== sim/ifs_tb.sv ====
// Testbench of the fetch stage; models the instruction bus and memory and drives random control
`timescale 1ns/1ps

module ifs_tb;
  import ifs_pkg::*;

  localparam int          STIM_CYCLES    = 3000;
  localparam int          TIMEOUT_CYCLES = 4000;
  localparam int          MEM_WORDS      = 1024;
  localparam logic [31:0] BOOT_ADDR      = 32'h0000_0080;
  localparam logic [15:0] LFSR_SEED      = 16'h1d2b;

  logic        clk;
  logic        rst_n;
  obi_req_t    obi_req;
  obi_resp_t   obi_resp;
  ctrl_fsm_t   ctrl_fsm;
  logic        dummy_en;
  if_id_pipe_t if_id_pipe;
  logic        if_valid;
  logic        id_ready;

  // The memory repeats every 4 KiB so that any fetch address has data
  logic [31:0] mem [MEM_WORDS];
  logic [31:0] rnd;
  int          cycle_cnt = 0;
  int          gnt_wait;
  logic [31:0] resp_addr_q [$];
  int          resp_due_q [$];
  // Model of the pc and privilege the next entry must carry
  logic [31:0] exp_pc;
  privlvl_t    exp_priv;

  ifs_if_stage #(
    .BOOT_ADDR (BOOT_ADDR),
    .LFSR_SEED (LFSR_SEED)
  ) dut_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .obi_req_o    (obi_req),
    .obi_resp_i   (obi_resp),
    .ctrl_fsm_i   (ctrl_fsm),
    .dummy_en_i   (dummy_en),
    .if_id_pipe_o (if_id_pipe),
    .if_valid_o   (if_valid),
    .id_ready_i   (id_ready)
  );

  bind ifs_if_stage ifs_if_stage_chk chk_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .obi_req_o    (obi_req_o),
    .obi_resp_i   (obi_resp_i),
    .ctrl_fsm_i   (ctrl_fsm_i),
    .dummy_en_i   (dummy_en_i),
    .if_id_pipe_o (if_id_pipe_o),
    .if_valid_o   (if_valid_o),
    .id_ready_i   (id_ready_i)
  );

  initial clk = 1'b0;
  always #50 clk = ~clk;

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [15:0] mem_half(input logic [31:0] addr);
    logic [31:0] w;
    w = mem[addr[11:2]];
    return addr[1] ? w[31:16] : w[15:0];
  endfunction

  function automatic logic [31:0] mem_instr(input logic [31:0] addr);
    return {mem_half(addr + 32'd2), mem_half(addr)};
  endfunction

  // Low bits other than 11 make a 16-bit instruction
  function automatic logic [31:0] insn_len(input logic [31:0] addr);
    logic [15:0] h;
    h = mem_half(addr);
    return (h[1:0] != 2'b11) ? 32'd2 : 32'd4;
  endfunction

  // C.LW, C.SW, C.ADDI, C.LI, C.J, C.MV and C.ADD are expanded, all else is illegal
  function automatic logic rvc_supported(input logic [15:0] h);
    logic [2:0] f3;
    f3 = h[15:13];
    case (h[1:0])
      2'b00:   return (f3 == 3'b010) || (f3 == 3'b110);
      2'b01:   return (f3 == 3'b000) || (f3 == 3'b010) || (f3 == 3'b101);
      2'b10:   return (f3 == 3'b100) && (h[6:2] != 5'd0);
      default: return 1'b0;
    endcase
  endfunction

  task automatic stop_run();
    $display("ERRORS FOUND");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic report_fail(input string msg);
    $display("[FAIL] %0t %s", $time, msg);
    stop_run();
  endtask

  // Grants come after 0 to 3 waiting cycles and data 1 to 4 cycles after the grant
  task automatic drive_bus();
    logic [31:0] addr;
    rnd = xorshift(rnd);
    obi_resp.gnt    = 1'b0;
    obi_resp.rvalid = 1'b0;
    if (resp_due_q.size() != 0 && resp_due_q[0] <= cycle_cnt) begin
      addr = resp_addr_q.pop_front();
      void'(resp_due_q.pop_front());
      obi_resp.rvalid = 1'b1;
      obi_resp.rdata  = mem[addr[11:2]];
    end
    if (obi_req.req) begin
      if (gnt_wait == 0) begin
        obi_resp.gnt = 1'b1;
        resp_addr_q.push_back(obi_req.addr);
        resp_due_q.push_back(cycle_cnt + 1 + int'(rnd[1:0]));
        gnt_wait = int'(rnd[3:2]);
      end else begin
        gnt_wait--;
      end
    end
  endtask

  // Back-pressure on a quarter of the cycles, halts and kills now and then
  task automatic drive_ctrl();
    rnd = xorshift(rnd);
    id_ready             = (rnd[1:0] != 2'b00);
    ctrl_fsm.halt_if     = (rnd[5:2] == 4'd0);
    ctrl_fsm.kill_if     = (rnd[10:6] == 5'd0);
    ctrl_fsm.branch_addr = {20'h0, rnd[22:11]};
    ctrl_fsm.priv_lvl    = rnd[23] ? PRIV_LVL_M : PRIV_LVL_U;
    if (rnd[31:26] == 6'd0) begin
      dummy_en = ~dummy_en;
    end
  endtask

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      exp_pc   <= BOOT_ADDR;
      exp_priv <= PRIV_LVL_M;
    end else if (ctrl_fsm.kill_if) begin
      exp_pc   <= {ctrl_fsm.branch_addr[31:1], 1'b0};
      exp_priv <= ctrl_fsm.priv_lvl;
    end else if (if_valid && id_ready && !if_id_pipe.dummy) begin
      exp_pc <= exp_pc + insn_len(exp_pc);
    end
  end

  //////////////////////////////
  // Checks against the model
  //////////////////////////////

  // Dummies report the pc of the instruction they precede
  assert property (@(posedge clk) disable iff (!rst_n)
    if_valid |-> if_id_pipe.pc == exp_pc)
    else report_fail("pc is neither the next sequential pc nor the kill target");

  assert property (@(posedge clk) disable iff (!rst_n)
    if_valid |-> if_id_pipe.priv_lvl == exp_priv)
    else report_fail("privilege level differs from the one set by the last kill");

  assert property (@(posedge clk) disable iff (!rst_n)
    if_valid && !if_id_pipe.dummy |-> if_id_pipe.compressed == (insn_len(exp_pc) == 32'd2))
    else report_fail("compressed flag does not match the halfword in memory");

  assert property (@(posedge clk) disable iff (!rst_n)
    if_valid && !if_id_pipe.dummy && !if_id_pipe.compressed |->
      if_id_pipe.instr == mem_instr(exp_pc) && !if_id_pipe.illegal_c_insn)
    else report_fail("32-bit instruction differs from memory or is flagged illegal");

  assert property (@(posedge clk) disable iff (!rst_n)
    if_valid && !if_id_pipe.dummy && if_id_pipe.compressed |->
      if_id_pipe.illegal_c_insn == !rvc_supported(mem_half(exp_pc)))
    else report_fail("illegal_c_insn wrong for the compressed halfword");

  // Legal halfwords expand to a 32-bit encoding, illegal ones keep their bits
  assert property (@(posedge clk) disable iff (!rst_n)
    if_valid && !if_id_pipe.dummy && if_id_pipe.compressed |->
      (if_id_pipe.illegal_c_insn ? (if_id_pipe.instr[15:0] == mem_half(exp_pc)) :
                                   (if_id_pipe.instr[1:0] == 2'b11)))
    else report_fail("compressed instruction not expanded or not passed through");

  // Failures of the bound checker end the run here
  always @(negedge clk) begin
    if (dut_i.chk_i.fail_count != 0) begin
      report_fail("assertion in the bound checker failed");
    end
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("simulation did not finish within %0d cycles", TIMEOUT_CYCLES);
      stop_run();
    end
  end

  initial begin
    rnd = 32'h13d8;
    for (int i = 0; i < MEM_WORDS; i++) begin
      rnd    = xorshift(rnd);
      mem[i] = rnd;
      // C.LI a0,1 in some low halves
      if (i % 5 == 0) begin
        mem[i][15:0] = 16'h4505;
      end
      // All-zero halfwords are always illegal
      if (i % 7 == 3) begin
        mem[i][31:16] = 16'h0000;
      end
      // C.JR ra lies outside the expanded subset
      if (i % 11 == 6) begin
        mem[i][15:0] = 16'h8082;
      end
    end
    rst_n             = 1'b0;
    obi_resp          = '0;
    ctrl_fsm          = '0;
    ctrl_fsm.priv_lvl = PRIV_LVL_M;
    dummy_en          = 1'b0;
    id_ready          = 1'b0;
    gnt_wait          = 0;
    repeat (5) @(negedge clk);
    rst_n = 1'b1;
    repeat (STIM_CYCLES) begin
      @(negedge clk);
      drive_bus();
      drive_ctrl();
    end
    @(negedge clk);
    if (dut_i.chk_i.fail_count != 0) begin
      report_fail("assertion in the bound checker failed");
    end else begin
      $display("NO ERRORS");
      $finish;
    end
  end

endmodule

// ==== ifs.f ====
rtl/ifs_pkg.sv
rtl/ifs_prefetch_buffer.sv
rtl/ifs_aligner.sv
rtl/ifs_compressed_decoder.sv
rtl/ifs_dummy_inserter.sv
rtl/ifs_if_stage.sv
sim/ifs_if_stage_chk.sv
sim/ifs_tb.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TOP        := ifs_tb
FILELIST   := ifs.f
OBJ_DIR    := obj_dir
FLAGS      := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing -Wall
RUN_ARGS   := +verilator+error+limit+100
PASS_TEXT  := NO ERRORS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(RUN_ARGS) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
